/* design/data_mem.sv */
// word memory, only wb_adr[AW-1:2] decoded; ack one cycle after stb, so every cycle takes 2 clocks
`default_nettype none

module data_mem (
	input  logic            clock,
	input  logic            rst,
	input  logic            wb_cyc,
	input  logic            wb_stb,
	input  logic            wb_we,
	input  mem_pkg::addr_t  wb_adr,
	input  mem_pkg::sel_t   wb_sel,
	input  mem_pkg::xlen_t  wb_dat_w,
	output mem_pkg::xlen_t  wb_dat_r,
	output logic            wb_ack
);
	import mem_pkg::*;

	xlen_t         mem [DMEM_WORDS];
	logic [AW-3:0] widx;            // word index
	logic          req;             // first cycle of a bus cycle

	assign widx     = wb_adr[AW-1:2];
	assign req      = wb_cyc & wb_stb & ~wb_ack;
	assign wb_dat_r = mem[widx];    // async read, valid by ack

	//////////////////////////////////////////////////
	// storage and handshake
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				mem[i] <= '0;           // reads of unwritten words give zero
			end
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;              // single pulse per cycle
			if (req && wb_we) begin
				for (int b = 0; b < XLEN / 8; b++) begin
					if (wb_sel[b])
						mem[widx][8*b +: 8] <= wb_dat_w[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/lb_if.sv */
// one load buffer slot link; grant is a one-cycle pulse and the slot frees on the next edge
`default_nettype none

interface lb_if;
	import mem_pkg::*;

	// allocator side, write port of the slot
	logic      wr;           // write strobe
	addr_t     wr_addr;
	mem_size_t wr_size;
	logic      wr_uns;       // zero extend
	tag_t      wr_tag;

	// slot contents
	logic      busy;
	addr_t     addr;
	mem_size_t size;
	logic      uns;
	tag_t      tag;

	logic      grant;        // mem stage took it

	modport alloc (output wr, wr_addr, wr_size, wr_uns, wr_tag,
		input busy);

	modport entry (input wr, wr_addr, wr_size, wr_uns, wr_tag, grant,
		output busy, addr, size, uns, tag);

	modport mem (input busy, addr, size, uns, tag,
		output grant);

endinterface

`default_nettype wire

/* design/load_alloc.sv */
// loads go to the lowest free slot; ld_ready stays low one cycle after reset and while full
`default_nettype none

module load_alloc (
	input  logic                clock,
	input  logic                rst,
	input  logic                ld_valid,
	input  logic                ld_uns,
	input  mem_pkg::addr_t      ld_addr,
	input  mem_pkg::mem_size_t  ld_size,
	input  mem_pkg::tag_t       ld_tag,
	output logic                ld_ready,
	lb_if.alloc                 lbs [mem_pkg::N_LB]
);
	import mem_pkg::*;

	logic [N_LB-1:0] busy;      // gathered from slots
	logic [N_LB-1:0] wr_vec;
	lb_idx_t         free_idx;
	logic            rdy_en;    // low for first cycle out of reset
	logic            take;

	//////////////////////////////////////////////////
	// pick a slot
	//////////////////////////////////////////////////
	assign free_idx = first_set(~busy);          // lowest free
	assign ld_ready = rdy_en & ~&busy;
	assign take     = ld_valid & ld_ready;

	always_ff @(posedge clock) begin
		if (rst)
			rdy_en <= 1'b0;
		else
			rdy_en <= 1'b1;
	end

	// request fields are broadcast, wr picks the slot
	for (genvar i = 0; i < N_LB; i++) begin : g_wr
		assign busy[i]        = lbs[i].busy;
		assign wr_vec[i]      = take && (free_idx == LB_IDX_W'(i));
		assign lbs[i].wr      = wr_vec[i];
		assign lbs[i].wr_addr = ld_addr;
		assign lbs[i].wr_size = ld_size;
		assign lbs[i].wr_uns  = ld_uns;
		assign lbs[i].wr_tag  = ld_tag;
	end

	// one slot per accepted load
	a_one_wr: assert property (@(posedge clock) disable iff (rst) $onehot0(wr_vec));

	// slot must hold its load until granted
	a_wr_free: assert property (@(posedge clock) disable iff (rst) (wr_vec & busy) == '0);

endmodule

`default_nettype wire

/* design/load_entry.sv */
// single pending load; written and granted never in the same cycle
`default_nettype none

module load_entry (
	input  logic clock,
	input  logic rst,
	lb_if.entry  lb
);
	import mem_pkg::*;

	logic      busy_q;
	addr_t     addr_q;
	mem_size_t size_q;
	logic      uns_q;
	tag_t      tag_q;

	// occupancy
	always_ff @(posedge clock) begin
		if (rst) begin
			busy_q <= 1'b0;
		end else if (lb.wr) begin
			busy_q <= 1'b1;              // filled by allocator
		end else if (lb.grant) begin
			busy_q <= 1'b0;              // mem stage took it
		end
	end

	// load fields, held while busy
	always_ff @(posedge clock) begin
		if (lb.wr) begin
			addr_q <= lb.wr_addr;
			size_q <= lb.wr_size;
			uns_q  <= lb.wr_uns;
			tag_q  <= lb.wr_tag;
		end
	end

	assign lb.busy = busy_q;
	assign lb.addr = addr_q;
	assign lb.size = size_q;
	assign lb.uns  = uns_q;
	assign lb.tag  = tag_q;

	// mem stage only picks occupied slots
	a_grant_busy: assert property (@(posedge clock) disable iff (rst) lb.grant |-> busy_q);

endmodule

`default_nettype wire

/* design/mem_pkg.sv */
// RV32 only: DOUBLE is never legal, and DMEM_WORDS must equal 2**(AW-2)
`default_nettype none

package mem_pkg;

	//////////////////////////////////////////////////
	// sizing
	//////////////////////////////////////////////////
	localparam int XLEN       = 32;              // data word
	localparam int N_LB       = 4;               // load buffer depth
	localparam int LB_IDX_W   = $clog2(N_LB);
	localparam int TAG_W      = 4;               // load id
	localparam int DMEM_WORDS = 256;
	localparam int AW         = 10;              // byte address bits seen by dmem

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////
	typedef logic [XLEN-1:0]     xlen_t;
	typedef logic [31:0]         addr_t;         // only low AW bits decoded
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [XLEN/8-1:0]   sel_t;          // one bit per byte lane
	typedef logic [LB_IDX_W-1:0] lb_idx_t;

	typedef enum logic [1:0] {
		BYTE   = 2'b00,
		HALF   = 2'b01,
		WORD   = 2'b10,
		DOUBLE = 2'b11                           // rv64 only
	} mem_size_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		STORE
	} ms_state_t;

	// index of lowest set bit, 0 when none set
	function automatic lb_idx_t first_set(input logic [N_LB-1:0] v);
		lb_idx_t idx;
		idx = '0;
		for (int i = N_LB - 1; i >= 0; i--) begin
			if (v[i])
				idx = lb_idx_t'(i);
		end
		return idx;
	endfunction

endpackage

`default_nettype wire

/* design/mem_stage.sv */
// one classic Wishbone cycle at a time, stores first; naturally aligned BYTE/HALF/WORD only
`default_nettype none

module mem_stage (
	input  logic                clock,
	input  logic                rst,
	lb_if.mem                   lbs [mem_pkg::N_LB],
	input  logic                st_valid,
	input  mem_pkg::addr_t      st_addr,
	input  mem_pkg::mem_size_t  st_size,
	input  mem_pkg::xlen_t      st_data,
	output logic                st_ready,
	output logic                wb_cyc,
	output logic                wb_stb,
	output logic                wb_we,
	output mem_pkg::addr_t      wb_adr,
	output mem_pkg::sel_t       wb_sel,
	output mem_pkg::xlen_t      wb_dat_w,
	input  mem_pkg::xlen_t      wb_dat_r,
	input  logic                wb_ack,
	output logic                res_valid,
	output mem_pkg::tag_t       res_tag,
	output mem_pkg::xlen_t      res_data
);
	import mem_pkg::*;

	ms_state_t       state;
	logic            stb_q;
	logic [N_LB-1:0] lb_busy;
	addr_t           lb_addr [N_LB];
	mem_size_t       lb_size [N_LB];
	logic            lb_uns  [N_LB];
	tag_t            lb_tag  [N_LB];
	lb_idx_t         pick;            // lowest busy slot
	logic            ld_take;
	addr_t           cap_addr;
	mem_size_t       cap_size;
	sel_t            cap_sel;
	xlen_t           st_rep;          // store data on every lane
	mem_size_t       size_q;
	logic            uns_q;
	tag_t            tag_q;
	xlen_t           lane;
	xlen_t           ext;

	//////////////////////////////////////////////////
	// arbitration, commit stores win
	//////////////////////////////////////////////////
	for (genvar i = 0; i < N_LB; i++) begin : g_lb
		assign lb_busy[i]   = lbs[i].busy;
		assign lb_addr[i]   = lbs[i].addr;
		assign lb_size[i]   = lbs[i].size;
		assign lb_uns[i]    = lbs[i].uns;
		assign lb_tag[i]    = lbs[i].tag;
		assign lbs[i].grant = ld_take && (pick == LB_IDX_W'(i));
	end

	assign pick     = first_set(lb_busy);
	assign st_ready = (state == IDLE) & st_valid;
	assign ld_take  = (state == IDLE) & ~st_valid & |lb_busy;
	assign cap_addr = st_valid ? st_addr : lb_addr[pick];
	assign cap_size = st_valid ? st_size : lb_size[pick];

	always_comb begin
		case (cap_size)
			BYTE:    cap_sel = sel_t'(4'b0001 << cap_addr[1:0]);
			HALF:    cap_sel = sel_t'(4'b0011 << cap_addr[1:0]);
			default: cap_sel = '1;                      // word
		endcase
		case (st_size)
			BYTE:    st_rep = {4{st_data[7:0]}};
			HALF:    st_rep = {2{st_data[15:0]}};
			default: st_rep = st_data;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state     <= IDLE;
			stb_q     <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (st_ready) begin
						state <= STORE;
						stb_q <= 1'b1;
					end else if (ld_take) begin
						state <= LOAD;
						stb_q <= 1'b1;
					end
				end
				default: begin                              // LOAD, STORE
					if (wb_ack) begin
						state     <= IDLE;
						stb_q     <= 1'b0;
						res_valid <= (state == LOAD);
					end
				end
			endcase
		end
	end

	assign wb_cyc = (state != IDLE);
	assign wb_stb = stb_q;
	assign wb_we  = (state == STORE);

	//////////////////////////////////////////////////
	// bus payload and load return
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (st_ready | ld_take) begin
			wb_adr   <= cap_addr;
			wb_sel   <= cap_sel;
			wb_dat_w <= st_rep;           // don't care on loads
			size_q   <= cap_size;
			uns_q    <= lb_uns[pick];
			tag_q    <= lb_tag[pick];
		end
		if ((state == LOAD) && wb_ack) begin
			res_tag  <= tag_q;
			res_data <= ext;
		end
	end

	// shift lane down, then extend
	always_comb begin
		lane = wb_dat_r >> {wb_adr[1:0], 3'b000};
		case (size_q)
			BYTE:    ext = uns_q ? {{(XLEN-8){1'b0}}, lane[7:0]}
				: {{(XLEN-8){lane[7]}}, lane[7:0]};
			HALF:    ext = uns_q ? {{(XLEN-16){1'b0}}, lane[15:0]}
				: {{(XLEN-16){lane[15]}}, lane[15:0]};
			default: ext = lane;
		endcase
	end

	// rv32 never moves a double word
	a_no_double: assert property (@(posedge clock) disable iff (rst)
		(XLEN == 32) && (st_ready || ld_take) |-> cap_size != DOUBLE);

	a_aligned: assert property (@(posedge clock) disable iff (rst)
		(st_ready || ld_take) |->
		!((cap_size == HALF && cap_addr[0]) || (cap_size == WORD && cap_addr[1:0] != 2'b00)));

	// request and payload held steady until the slave acks
	a_stb_hold: assert property (@(posedge clock) disable iff (rst)
		wb_stb && !wb_ack |=> wb_stb && wb_cyc && $stable(wb_adr) && $stable(wb_sel)
		&& $stable(wb_we) && $stable(wb_dat_w));

endmodule

`default_nettype wire

/* design/mem_subsys.sv */
// top level; result port has no ready, the consumer takes every res_valid pulse
`default_nettype none

module mem_subsys (
	input  logic                clock,
	input  logic                rst,
	// load request from issue
	input  logic                ld_valid,
	output logic                ld_ready,
	input  mem_pkg::addr_t      ld_addr,
	input  mem_pkg::mem_size_t  ld_size,
	input  logic                ld_uns,
	input  mem_pkg::tag_t       ld_tag,
	// store from commit
	input  logic                st_valid,
	output logic                st_ready,
	input  mem_pkg::addr_t      st_addr,
	input  mem_pkg::mem_size_t  st_size,
	input  mem_pkg::xlen_t      st_data,
	// load result
	output logic                res_valid,
	output mem_pkg::tag_t       res_tag,
	output mem_pkg::xlen_t      res_data
);
	import mem_pkg::*;

	logic  wb_cyc, wb_stb, wb_we, wb_ack;
	addr_t wb_adr;
	sel_t  wb_sel;
	xlen_t wb_dat_w, wb_dat_r;

	lb_if lbs [N_LB] ();            // one link per slot

	load_alloc u_load_alloc (.clock, .rst, .ld_valid, .ld_uns, .ld_addr, .ld_size,
		.ld_tag, .ld_ready, .lbs(lbs));

	for (genvar i = 0; i < N_LB; i++) begin : g_lb
		load_entry u_load_entry (.clock, .rst, .lb(lbs[i]));
	end

	mem_stage u_mem_stage (.clock, .rst, .lbs(lbs), .st_valid, .st_addr, .st_size,
		.st_data, .st_ready, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_w,
		.wb_dat_r, .wb_ack, .res_valid, .res_tag, .res_data);

	data_mem u_data_mem (.clock, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel,
		.wb_dat_w, .wb_dat_r, .wb_ack);

endmodule

`default_nettype wire

/* dv/tb_mem_subsys.sv */
// random traffic against a byte model; loads must never overlap an address with a store in flight
`default_nettype none

module tb_mem_subsys;
	timeunit 1ns;
	timeprecision 100ps;
	import mem_pkg::*;

	localparam int SEED   = 32'h5ef4e6e8;
	localparam int N_ST1  = 64;
	localparam int N_SGN  = 8;                   // words with top bits set
	localparam int MIX_CY = 300;
	localparam int TXN    = 2 * N_ST1 + 13 * N_SGN + (N_LB + 2) + (N_LB + 4) + 8
		+ 2 * MIX_CY + 8;
	localparam int WD_CYCLES = TXN * 20;

	logic      clock, rst;
	logic      ld_valid, ld_ready, ld_uns, st_valid, st_ready, res_valid;
	addr_t     ld_addr, st_addr;
	mem_size_t ld_size, st_size;
	tag_t      ld_tag, res_tag;
	xlen_t     st_data, res_data;

	logic [7:0]          model_mem [2**AW];      // byte image of dmem
	xlen_t               exp_data [2**TAG_W];    // scoreboard by tag
	logic [2**TAG_W-1:0] in_flight;
	tag_t                next_tag;
	int mon_errors, mon_checks, tb_errors, tb_checks;
	int cycle, res_count, full_cycles;
	int seed_val;

	mem_subsys u_mem_subsys (.clock, .rst, .ld_valid, .ld_ready, .ld_addr, .ld_size, .ld_uns,
		.ld_tag, .st_valid, .st_ready, .st_addr, .st_size, .st_data, .res_valid, .res_tag,
		.res_data);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// model and scoreboard
	//////////////////////////////////////////////////
	function automatic xlen_t expect_load(input addr_t a, input mem_size_t sz, input logic uns);
		logic [AW-1:0] b;
		logic [15:0]   h;
		b = a[AW-1:0];
		h = {model_mem[b + AW'(1)], model_mem[b]};
		case (sz)
			BYTE:    return uns ? {24'h0, model_mem[b]} : {{24{model_mem[b][7]}}, model_mem[b]};
			HALF:    return uns ? {16'h0, h} : {{16{h[15]}}, h};
			default: return {model_mem[b + AW'(3)], model_mem[b + AW'(2)], h};
		endcase
	endfunction

	task automatic model_store(input addr_t a, input mem_size_t sz, input xlen_t d);
		logic [AW-1:0] b;
		b = a[AW-1:0];
		model_mem[b] = d[7:0];
		if (sz != BYTE)
			model_mem[b + AW'(1)] = d[15:8];
		if (sz == WORD) begin
			model_mem[b + AW'(2)] = d[23:16];
			model_mem[b + AW'(3)] = d[31:24];
		end
	endtask

	// outputs sampled mid-cycle, inputs move only just after the rising edge
	always @(negedge clock) begin
		if (rst) begin
			for (int i = 0; i < 2**AW; i++)
				model_mem[i] = 8'h00;                // dmem clears on reset
			in_flight = '0;
		end else begin
			cycle++;
			if (!ld_ready)
				full_cycles++;
			if (res_valid) begin
				res_count++;
				mon_checks++;
				if (!in_flight[res_tag]) begin
					mon_errors++;
					$display("result at %0t carries tag %0d, which has no load in flight",
						$time, res_tag);
				end else if (res_data !== exp_data[res_tag]) begin
					mon_errors++;
					$display("ERROR %0t res_data (tag %0d): expected %h, got %h", $time,
						res_tag, exp_data[res_tag], res_data);
				end
				in_flight[res_tag] = 1'b0;
			end
			if (st_valid && st_ready)
				model_store(st_addr, st_size, st_data);   // effect taken at acceptance
			if (ld_valid && ld_ready) begin
				if (in_flight[ld_tag]) begin
					mon_errors++;
					$display("load at %0t reused tag %0d still in flight", $time, ld_tag);
				end
				exp_data[ld_tag]  = expect_load(ld_addr, ld_size, ld_uns);
				in_flight[ld_tag] = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// drivers, entered and left at edge + 10 ns
	//////////////////////////////////////////////////
	function automatic mem_size_t rand_size();
		logic [1:0] s;
		s = 2'($urandom_range(0, 2));               // never DOUBLE
		return mem_size_t'(s);
	endfunction

	function automatic addr_t rand_aligned(input int base, input int span, input mem_size_t sz);
		addr_t a;
		a = addr_t'(base) + addr_t'($urandom_range(0, span - 1));
		case (sz)
			BYTE:    return a;
			HALF:    return {a[31:1], 1'b0};
			default: return {a[31:2], 2'b00};
		endcase
	endfunction

	task automatic idle(input int n);
		repeat (n) @(posedge clock);
		#10;
	endtask

	task automatic load_issue(input addr_t a, input mem_size_t sz, input logic uns);
		for (int i = 0; i < 2**TAG_W && in_flight[next_tag]; i++)
			next_tag = next_tag + tag_t'(1);        // skip tags still out
		ld_valid = 1'b1;
		ld_addr  = a;
		ld_size  = sz;
		ld_uns   = uns;
		ld_tag   = next_tag;
		do @(negedge clock); while (!ld_ready);
		@(posedge clock);
		#10;
		ld_valid = 1'b0;
		next_tag = next_tag + tag_t'(1);
	endtask

	task automatic store_issue(input addr_t a, input mem_size_t sz, input xlen_t d);
		int r0;
		st_valid = 1'b1;
		st_addr  = a;
		st_size  = sz;
		st_data  = d;
		r0       = res_count;
		do @(negedge clock); while (!st_ready);
		@(posedge clock);
		#10;
		st_valid = 1'b0;
		tb_checks++;
		// only the load already on the bus may finish ahead of a waiting store
		if (res_count - r0 > 1) begin
			tb_errors++;
			$display("store to %h at %0t waited behind %0d load results", a, $time,
				res_count - r0);
		end
	endtask

	task automatic wait_drain();
		do begin
			@(posedge clock);
			#10;
		end while (in_flight != '0);
		idle(2);                                     // last store off the bus
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		tb_checks++;
		if (got !== exp) begin
			tb_errors++;
			$display("ERROR %0t %s: expected %b, got %b", $time, name, exp, got);
		end
	endtask

	task automatic report_test(input string name, input int e0);
		$display("test %s done: %0d errors", name, tb_errors + mon_errors - e0);
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////
	initial begin
		addr_t     st_list [N_ST1];
		addr_t     pri_addr [4];
		mem_size_t pri_size [4];
		mem_size_t sz;
		int        e0, r0, f0, c_end;
		seed_val = $urandom(SEED);
		rst = 1'b1;
		{ld_valid, ld_uns, st_valid} = '0;
		ld_addr = '0;
		st_addr = '0;
		ld_size = BYTE;
		st_size = BYTE;
		ld_tag = '0;
		st_data = '0;
		next_tag = '0;
		{mon_errors, mon_checks, tb_errors, tb_checks} = '0;
		{cycle, res_count, full_cycles} = '0;
		repeat (5) @(posedge clock);
		#10;
		rst = 1'b0;

		// reset state, then reads of untouched words
		e0 = tb_errors + mon_errors;
		@(negedge clock);
		check_bit("res_valid", 1'b0, res_valid);
		check_bit("st_ready", 1'b0, st_ready);
		check_bit("ld_ready", 1'b0, ld_ready);      // first cycle out of reset
		idle(1);
		for (int i = 0; i < 8; i++) begin
			sz = rand_size();
			load_issue(rand_aligned(768, 256, sz), sz, 1'($urandom_range(0, 1)));
		end
		wait_drain();
		report_test("reset state", e0);

		// every size, store then load back
		e0 = tb_errors + mon_errors;
		for (int i = 0; i < N_ST1; i++) begin
			sz = rand_size();
			st_list[i] = rand_aligned(0, 256, sz);
			store_issue(st_list[i], sz, $urandom);
		end
		for (int i = 0; i < N_ST1; i++) begin
			sz = rand_size();
			load_issue(rand_aligned(int'(st_list[i]), 1, sz), sz, 1'($urandom_range(0, 1)));
		end
		wait_drain();
		report_test("store then load", e0);

		// top bit set in every byte lane
		e0 = tb_errors + mon_errors;
		for (int w = 0; w < N_SGN; w++)
			store_issue(addr_t'(256 + 4 * w), WORD, $urandom | 32'h8080_8080);
		for (int w = 0; w < N_SGN; w++) begin
			for (int b = 0; b < 4; b++) begin
				load_issue(addr_t'(256 + 4 * w + b), BYTE, 1'b0);
				load_issue(addr_t'(256 + 4 * w + b), BYTE, 1'b1);
			end
			for (int h = 0; h < 4; h += 2) begin
				load_issue(addr_t'(256 + 4 * w + h), HALF, 1'b0);
				load_issue(addr_t'(256 + 4 * w + h), HALF, 1'b1);
			end
		end
		wait_drain();
		report_test("sign extension", e0);

		// back to back loads, no stores
		e0 = tb_errors + mon_errors;
		r0 = res_count;
		f0 = full_cycles;
		for (int i = 0; i < N_LB + 2; i++)
			load_issue(rand_aligned(0, 256, WORD), WORD, 1'b0);
		wait_drain();
		tb_checks++;
		if (full_cycles == f0) begin
			tb_errors++;
			$display("ld_ready never dropped while the load buffer was full");
		end
		tb_checks++;
		if (res_count - r0 != N_LB + 2) begin
			tb_errors++;
			$display("ERROR %0t result count: expected %0d, got %0d", $time, N_LB + 2,
				res_count - r0);
		end
		report_test("buffer full", e0);

		// stores arrive while the buffer holds loads
		e0 = tb_errors + mon_errors;
		fork
			begin
				for (int i = 0; i < N_LB + 4; i++)
					load_issue(rand_aligned(0, 256, WORD), WORD, 1'b0);
			end
			begin
				idle(2);
				for (int i = 0; i < 4; i++) begin
					pri_size[i] = rand_size();
					pri_addr[i] = rand_aligned(384 + 16 * i, 16, pri_size[i]);
					store_issue(pri_addr[i], pri_size[i], $urandom);
				end
			end
		join
		wait_drain();
		for (int i = 0; i < 4; i++)
			load_issue(pri_addr[i], pri_size[i], 1'($urandom_range(0, 1)));
		wait_drain();
		report_test("store priority", e0);

		// mixed, loads low half and stores high half
		e0 = tb_errors + mon_errors;
		c_end = cycle + MIX_CY;
		fork
			begin
				while (cycle < c_end) begin
					if ($urandom_range(0, 1) == 1) begin
						sz = rand_size();
						load_issue(rand_aligned(0, 512, sz), sz, 1'($urandom_range(0, 1)));
					end else begin
						idle(1);
					end
				end
			end
			begin
				while (cycle < c_end) begin
					if ($urandom_range(0, 3) == 0)
						store_issue(rand_aligned(512, 512, WORD), WORD, $urandom);
					else
						idle(1);
				end
			end
		join
		wait_drain();
		report_test("mixed traffic", e0);

		$display("tests done: %0d checks, %0d errors", tb_checks + mon_checks,
			tb_errors + mon_errors);
		if (tb_errors + mon_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// bound on total run length
	initial begin
		repeat (WD_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles, run did not finish", WD_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
design/mem_pkg.sv
design/lb_if.sv
design/load_alloc.sv
design/load_entry.sv
design/mem_stage.sv
design/data_mem.sv
design/mem_subsys.sv
dv/tb_mem_subsys.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module tb_mem_subsys -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
